//--- src/rv_pkg.sv
package rv_pkg;

    // ==========================================================
    // Basic constants
    // ==========================================================

    localparam int XLEN = 32;

    // addi x0,x0,0
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

    // Only the opcodes this core executes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // Encoded as {funct7[5], funct3} so decode is a plain concatenation
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } alu_op_e;

    // ==========================================================
    // Instruction formats
    // ==========================================================

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One word, five views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

    // ==========================================================
    // Pipeline payloads
    // ==========================================================

    typedef struct packed {
        logic    reg_write;
        logic    alu_src;      // Operand B from immediate
        logic    auipc;
        logic    lui;
        logic    branch;
        logic    jal;
        logic    jalr;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_plus_4;
        instr_t          instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_plus_4;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic [XLEN-1:0] rdata1;
        logic [XLEN-1:0] rdata2;
        logic [XLEN-1:0] imm;
        ctrl_t           ctrl;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            reg_write;
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] pc;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

//--- src/alu.sv
module alu (
    input  rv_pkg::alu_op_e op_i,
    input  logic [31:0]     a_i,
    input  logic [31:0]     b_i,
    output logic [31:0]     result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv_pkg::ADD:  result_o = a_i + b_i;
            rv_pkg::SUB:  result_o = a_i - b_i;
            rv_pkg::SLL:  result_o = a_i << shamt;
            rv_pkg::SLT: begin
                result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            end
            rv_pkg::SLTU: begin
                result_o = {31'b0, a_i < b_i};
            end
            rv_pkg::XOR:  result_o = a_i ^ b_i;
            rv_pkg::SRL:  result_o = a_i >> shamt;
            rv_pkg::SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt);  // Sign fill
            end
            rv_pkg::OR:   result_o = a_i | b_i;
            rv_pkg::AND:  result_o = a_i & b_i;
            default:      result_o = a_i + b_i;
        endcase
    end

endmodule

//--- src/reg_file.sv
module reg_file (
    input  logic        clk,
    input  logic        rst_i,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    input  rv_pkg::wb_t wb_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o
);

    logic [31:0] regs [1:31];  // x0 is not stored
    logic        we;

    // Decode already drops writes to x0
    assign we = wb_i.valid && wb_i.reg_write;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    // Read ports with write-through
    always_comb begin
        rdata1_o = '0;
        rdata2_o = '0;
        if (raddr1_i != 5'd0) begin
            rdata1_o = (we && wb_i.rd == raddr1_i) ? wb_i.value : regs[raddr1_i];
        end
        if (raddr2_i != 5'd0) begin
            rdata2_o = (we && wb_i.rd == raddr2_i) ? wb_i.value : regs[raddr2_i];
        end
    end

endmodule

//--- src/fetch_stage.sv
module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
)(
    input  logic              clk,
    input  logic              rst_i,
    input  rv_pkg::redirect_t redirect_i,
    output logic [31:0]       imem_addr_o,
    input  logic [31:0]       imem_data_i,
    output rv_pkg::if_id_t    if_id_o
);

    logic [31:0] pc;
    logic [31:0] pc_plus_4;
    logic [31:0] next_pc;

    assign pc_plus_4 = pc + 32'd4;
    assign next_pc   = redirect_i.taken ? redirect_i.target : pc_plus_4;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    assign imem_addr_o = pc;  // Word is back before the next edge

    // ==========================================================
    // IF/ID register
    // ==========================================================

    always_ff @(posedge clk) begin
        if_id_o.pc        <= pc;
        if_id_o.pc_plus_4 <= pc_plus_4;
        if_id_o.instr     <= imem_data_i;
        if (rst_i || redirect_i.taken) begin
            if_id_o.instr <= rv_pkg::NOP_WORD;  // Squash the wrong-path fetch
        end
    end

endmodule

//--- src/decode_stage.sv
module decode_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  rv_pkg::if_id_t    if_id_i,
    input  rv_pkg::wb_t       wb_i,
    input  rv_pkg::redirect_t redirect_i,
    output rv_pkg::id_ex_t    id_ex_o
);

    rv_pkg::instr_t instr;
    rv_pkg::ctrl_t  ctrl;
    rv_pkg::id_ex_t id_ex_d;
    logic [31:0]    imm;
    logic [31:0]    rdata1;
    logic [31:0]    rdata2;

    assign instr = if_id_i.instr;

    reg_file reg_file_inst (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddr1_i (instr.r.rs1),
        .raddr2_i (instr.r.rs2),
        .wb_i     (wb_i),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    // ==========================================================
    // Control and immediate decode
    // ==========================================================

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = rv_pkg::ADD;
        imm         = '0;
        case (instr.r.opcode)
            rv_pkg::OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = rv_pkg::alu_op_e'({instr.r.funct7[5], instr.r.funct3});
            end
            rv_pkg::OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                // Bit 30 is immediate data except for SRAI
                ctrl.alu_op    = rv_pkg::alu_op_e'({
                    (instr.r.funct3 == 3'b101) & instr.r.funct7[5], instr.r.funct3});
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            rv_pkg::LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.lui       = 1'b1;
                imm = {instr.u.imm_31_12, 12'b0};
            end
            rv_pkg::AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.auipc     = 1'b1;  // PC + upper immediate through the ALU
                ctrl.alu_src   = 1'b1;
                imm = {instr.u.imm_31_12, 12'b0};
            end
            rv_pkg::BRANCH: begin
                ctrl.branch = 1'b1;
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            rv_pkg::JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jal       = 1'b1;
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            rv_pkg::JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.jalr      = 1'b1;
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            default: ;  // Unknown opcodes behave as NOP
        endcase
        if (instr.r.rd == 5'd0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    always_comb begin
        id_ex_d.pc        = if_id_i.pc;
        id_ex_d.pc_plus_4 = if_id_i.pc_plus_4;
        id_ex_d.rs1       = instr.r.rs1;
        id_ex_d.rs2       = instr.r.rs2;
        id_ex_d.rd        = instr.r.rd;
        id_ex_d.funct3    = instr.r.funct3;
        id_ex_d.rdata1    = rdata1;
        id_ex_d.rdata2    = rdata2;
        id_ex_d.imm       = imm;
        id_ex_d.ctrl      = ctrl;
    end

    // ==========================================================
    // ID/EX register
    // ==========================================================

    always_ff @(posedge clk) begin
        id_ex_o <= id_ex_d;
        if (rst_i || redirect_i.taken) begin
            id_ex_o.ctrl <= '0;  // Bubble
        end
    end

endmodule

//--- src/execute_stage.sv
module execute_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  rv_pkg::id_ex_t    id_ex_i,
    output rv_pkg::redirect_t redirect_o,
    output rv_pkg::wb_t       wb_o
);

    rv_pkg::ctrl_t ctrl;
    logic [31:0]   rs1_val;
    logic [31:0]   rs2_val;
    logic [31:0]   op_a;
    logic [31:0]   op_b;
    logic [31:0]   alu_result;
    logic [31:0]   jump_base;
    logic [31:0]   jump_sum;
    logic [31:0]   result;
    logic          branch_cond;

    assign ctrl = id_ex_i.ctrl;

    // ==========================================================
    // Forwarding from write-back
    // ==========================================================

    assign rs1_val = (wb_o.valid && wb_o.reg_write && wb_o.rd == id_ex_i.rs1)
                   ? wb_o.value : id_ex_i.rdata1;
    assign rs2_val = (wb_o.valid && wb_o.reg_write && wb_o.rd == id_ex_i.rs2)
                   ? wb_o.value : id_ex_i.rdata2;

    assign op_a = ctrl.auipc   ? id_ex_i.pc  : rs1_val;
    assign op_b = ctrl.alu_src ? id_ex_i.imm : rs2_val;

    alu alu_inst (
        .op_i     (ctrl.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result)
    );

    // ==========================================================
    // Branch and jump resolution
    // ==========================================================

    always_comb begin
        case (id_ex_i.funct3)
            3'b000:  branch_cond = rs1_val == rs2_val;                    // BEQ
            3'b001:  branch_cond = rs1_val != rs2_val;                    // BNE
            3'b100:  branch_cond = $signed(rs1_val) < $signed(rs2_val);   // BLT
            3'b101:  branch_cond = $signed(rs1_val) >= $signed(rs2_val);  // BGE
            3'b110:  branch_cond = rs1_val < rs2_val;                     // BLTU
            3'b111:  branch_cond = rs1_val >= rs2_val;                    // BGEU
            default: branch_cond = 1'b0;
        endcase
    end

    assign jump_base = ctrl.jalr ? rs1_val : id_ex_i.pc;
    assign jump_sum  = jump_base + id_ex_i.imm;

    assign redirect_o.taken  = (ctrl.branch && branch_cond) || ctrl.jal || ctrl.jalr;
    assign redirect_o.target = {jump_sum[31:1], jump_sum[0] & ~ctrl.jalr};

    // Link value for jumps, upper immediate for LUI
    assign result = ctrl.lui                ? id_ex_i.imm       :
                    (ctrl.jal || ctrl.jalr) ? id_ex_i.pc_plus_4 :
                                              alu_result;

    // ==========================================================
    // EX/WB register
    // ==========================================================

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_o.valid     <= 1'b0;
            wb_o.reg_write <= 1'b0;
        end else begin
            wb_o.valid     <= ctrl.reg_write;
            wb_o.reg_write <= ctrl.reg_write;
        end
        wb_o.rd    <= id_ex_i.rd;
        wb_o.value <= result;
        wb_o.pc    <= id_ex_i.pc;
    end

endmodule

//--- src/rv_core.sv
module rv_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
)(
    input  logic        clk,
    input  logic        rst_i,
    output logic [31:0] imem_addr_o,
    input  logic [31:0] imem_data_i,
    output logic        retire_valid_o,
    output logic [31:0] retire_pc_o,
    output logic [4:0]  retire_rd_o,
    output logic [31:0] retire_value_o
);

    rv_pkg::if_id_t    if_id;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::redirect_t redirect;
    rv_pkg::wb_t       wb;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .redirect_i  (redirect),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .if_id_o     (if_id)
    );

    decode_stage decode_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .if_id_i    (if_id),
        .wb_i       (wb),
        .redirect_i (redirect),
        .id_ex_o    (id_ex)
    );

    execute_stage execute_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .id_ex_i    (id_ex),
        .redirect_o (redirect),
        .wb_o       (wb)
    );

    // Retire trace straight off the write-back register
    assign retire_valid_o = wb.valid;
    assign retire_pc_o    = wb.pc;
    assign retire_rd_o    = wb.rd;
    assign retire_value_o = wb.value;

endmodule

//--- bench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;  // 40 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;  // Released on a falling edge
    end

endmodule

//--- bench/tb_checker.sv
module tb_checker #(
    parameter int PROG_LEN = 48
)(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        load_i,
    input  logic        end_i,
    input  int          test_id_i,
    input  logic [31:0] prog_i [0:PROG_LEN-1],
    input  logic        retire_valid_i,
    input  logic [31:0] retire_pc_i,
    input  logic [4:0]  retire_rd_i,
    input  logic [31:0] retire_value_i,
    output int          pending_o,
    output int          passed_o,
    output int          failed_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    int          errors;
    string       name;

    initial begin
        pending_o = 0;
        passed_o  = 0;
        failed_o  = 0;
        errors    = 0;
    end

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // ==========================================================
    // Instruction-set model that runs to the halt word
    // ==========================================================

    task run_model();
        logic [31:0] x [0:31];
        logic [31:0] pc, w, a, b, val, next_pc;
        logic [31:0] imm_i, imm_b, imm_u, imm_j;
        logic        wr;
        int          idx;
        for (int r = 0; r < 32; r++) x[r] = '0;
        exp_pc.delete();
        exp_rd.delete();
        exp_val.delete();
        pc = '0;
        for (int step = 0; step < 4 * PROG_LEN; step++) begin
            idx = int'(pc >> 2);
            if (idx >= PROG_LEN) break;
            w = prog_i[idx];
            if (w == 32'h0000_006f) break;  // jal x0,0
            a       = x[w[19:15]];
            b       = x[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_u   = {w[31:12], 12'b0};
            imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            val     = '0;
            case (w[6:0])
                7'h33: val = alu_model(w[14:12], w[30], a, b);
                7'h13: val = alu_model(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm_i);
                7'h37: val = imm_u;
                7'h17: val = pc + imm_u;
                7'h63: begin
                    wr = 1'b0;
                    if (branch_taken(w[14:12], a, b)) next_pc = pc + imm_b;
                end
                7'h6f: begin
                    val     = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                7'h67: begin
                    val     = pc + 32'd4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                x[w[11:7]] = val;
                exp_pc.push_back(pc);
                exp_rd.push_back(w[11:7]);
                exp_val.push_back(val);
            end
            pc = next_pc;
        end
    endtask

    // ==========================================================
    // Trace compare
    // ==========================================================

    always @(posedge clk) begin
        name = $sformatf("random_program_%0d", test_id_i);
        if (load_i) begin
            run_model();
            errors = 0;
        end else if (retire_valid_i && !rst_i) begin
            if (exp_pc.size() == 0) begin
                $display("%s: retire at pc %h after the model's last register write",
                         name, retire_pc_i);
                errors++;
            end else begin
                if (retire_pc_i != exp_pc[0]) begin
                    $display("FAILED %s pc: expected %h actual %h",
                             name, exp_pc[0], retire_pc_i);
                    errors++;
                end else if (retire_rd_i != exp_rd[0] || retire_value_i != exp_val[0]) begin
                    $display("FAILED %s pc %h: expected x%0d=%h actual x%0d=%h", name,
                             retire_pc_i, exp_rd[0], exp_val[0], retire_rd_i, retire_value_i);
                    errors++;
                end
                void'(exp_pc.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_val.pop_front());
            end
        end
        if (end_i) begin
            if (exp_pc.size() != 0) begin
                $display("%s: %0d register writes never retired", name, exp_pc.size());
                errors++;
            end
            if (errors == 0) begin
                passed_o++;
            end else begin
                failed_o++;
            end
            $display("%s: %s, %0d errors", name, (errors == 0) ? "ok" : "bad", errors);
        end
        pending_o = exp_pc.size();
    end

endmodule

//--- bench/rv_core_properties.sv
module rv_core_properties (
    input logic        clk,
    input logic        rst_i,
    input logic [31:0] imem_addr_o,
    input logic        retire_valid_o,
    input logic [4:0]  retire_rd_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // Failed assertion count

    // Three-deep pipeline so nothing retires early
    a_quiet_reset: assert property (@(posedge clk) rst_i |=> !retire_valid_o)
        else begin
            $error("Retire seen during reset");
            fail_count++;
        end

    a_quiet_start: assert property (@(posedge clk)
        $fell(rst_i) |-> !retire_valid_o ##1 !retire_valid_o ##1 !retire_valid_o)
        else begin
            $error("Retire seen within three cycles of reset release");
            fail_count++;
        end

    a_no_x0: assert property (@(posedge clk) retire_valid_o |-> retire_rd_o != 5'd0)
        else begin
            $error("Retire trace reports a write to x0");
            fail_count++;
        end

    a_aligned: assert property (@(posedge clk) disable iff (rst_i)
        imem_addr_o[1:0] == 2'b00)
        else begin
            $error("Fetch address is not word aligned");
            fail_count++;
        end

endmodule

bind rv_core rv_core_properties i_props (.*);

//--- bench/tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_TESTS   = 20;
    localparam int          PROG_LEN    = 48;
    localparam int          TEST_CYCLES = PROG_LEN * 3 + 20;
    localparam logic [31:0] HALT_WORD   = 32'h0000_006f;  // jal x0,0

    logic        clk;
    logic        rst_gen;
    logic        rst_tb;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;
    logic [31:0] mem [0:PROG_LEN-1];
    logic        target_mark [0:PROG_LEN-1];
    logic        load;
    logic        test_end;
    int          test_id;
    int          pending;
    int          passed;
    int          failed;
    int          cycles;
    integer      seed;

    assign rst = rst_gen | rst_tb;

    tb_clock_gen i_clock_gen (
        .clk_o (clk),
        .rst_o (rst_gen)
    );

    rv_core i_rv_core (
        .clk            (clk),
        .rst_i          (rst),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_value_o (retire_value)
    );

    tb_checker #(.PROG_LEN(PROG_LEN)) i_checker (
        .clk (clk), .rst_i (rst), .load_i (load), .end_i (test_end),
        .test_id_i (test_id), .prog_i (mem),
        .retire_valid_i (retire_valid), .retire_pc_i (retire_pc),
        .retire_rd_i (retire_rd), .retire_value_i (retire_value),
        .pending_o (pending), .passed_o (passed), .failed_o (failed)
    );

    // Instruction memory answers on the falling edge
    always @(negedge clk) begin
        if (int'(imem_addr >> 2) < PROG_LEN) begin
            imem_data <= mem[int'(imem_addr >> 2)];
        end else begin
            imem_data <= HALT_WORD;
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int pick_skip(input int room, input int limit);
        return 1 + rand_below((room < limit) ? room : limit);
    endfunction

    // ==========================================================
    // Random program generator
    // ==========================================================

    task build_program();
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          i, kind, room, k;
        for (int n = 0; n < PROG_LEN; n++) target_mark[n] = 1'b0;
        i = 0;
        while (i < PROG_LEN - 1) begin
            kind = rand_below(12);
            rd   = 5'(rand_below(8));  // Small register set for many dependences
            rs1  = 5'(rand_below(8));
            rs2  = 5'(rand_below(8));
            f3   = 3'(rand_below(8));
            imm  = 12'(rand_below(4096));
            room = PROG_LEN - 1 - i;
            if (kind == 11 && (room < 2 || target_mark[i + 1])) kind = 3;
            case (kind)
                0, 1, 2: begin
                    mem[i] = {((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1)
                              ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
                end
                3, 4, 5: begin
                    if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                    if (f3 == 3'd5) imm = {rand_below(2) == 1 ? 7'h20 : 7'h00, imm[4:0]};
                    mem[i] = {imm, rs1, f3, rd, 7'h13};
                end
                6: mem[i] = {20'(rand_below(1 << 20)), rd, 7'h37};
                7: mem[i] = {20'(rand_below(1 << 20)), rd, 7'h17};
                8, 9: begin
                    k = pick_skip(room, 6);
                    target_mark[i + k] = 1'b1;
                    case (rand_below(6))
                        0: f3 = 3'd0;
                        1: f3 = 3'd1;
                        2: f3 = 3'd4;
                        3: f3 = 3'd5;
                        4: f3 = 3'd6;
                        default: f3 = 3'd7;
                    endcase
                    imm = 12'(k * 4);  // Forward offset with the sign bit clear
                    mem[i] = {1'b0, imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
                end
                10: begin
                    k = pick_skip(room, 6);
                    target_mark[i + k] = 1'b1;
                    imm = 12'(k * 4);
                    mem[i] = {1'b0, imm[10:1], imm[11], 8'h00, rd, 7'h6f};
                end
                default: begin
                    // auipc x31,0 then jalr rd,x31,off
                    k = pick_skip(room - 1, 5);
                    target_mark[i + 1 + k] = 1'b1;
                    mem[i]     = {20'h00000, 5'd31, 7'h17};
                    mem[i + 1] = {12'((k + 1) * 4), 5'd31, 3'd0, rd, 7'h67};
                    i++;
                end
            endcase
            i++;
        end
        mem[PROG_LEN - 1] = HALT_WORD;
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial begin
        seed      = 32'hf301b9eb;
        rst_tb    = 1'b0;
        load      = 1'b0;
        test_end  = 1'b0;
        test_id   = 0;
        imem_data = 32'h0000_0013;
        wait (!rst_gen);
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            test_id = t;
            build_program();
            rst_tb = 1'b1;
            load   = 1'b1;
            @(negedge clk);
            load = 1'b0;
            @(negedge clk);
            rst_tb = 1'b0;
            cycles = 0;
            while (pending != 0 && cycles < PROG_LEN * 3 + 4) begin
                @(negedge clk);
                cycles++;
            end
            repeat (8) @(negedge clk);  // Stay in the halt loop so a stray retire shows
            test_end = 1'b1;
            @(negedge clk);
            test_end = 1'b0;
        end
        @(negedge clk);
        $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 NUM_TESTS, passed, failed, i_rv_core.i_props.fail_count);
        if (failed == 0 && passed == NUM_TESTS && i_rv_core.i_props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 40);
        $display("Watchdog expired after %0d cycles, the test sequence hung",
                 NUM_TESTS * TEST_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- rv_core.f
src/rv_pkg.sv
src/alu.sv
src/reg_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv_core.sv
bench/tb_clock_gen.sv
bench/tb_checker.sv
bench/rv_core_properties.sv
bench/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_core -Mdir obj_dir -f rv_core.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "Simulation log has no result line"
    exit 1
fi
exit 0
